//--- sd_host_cfg.svh
`ifndef SD_HOST_CFG_SVH
`define SD_HOST_CFG_SVH

// ====================
// Command line framing
// ====================

// Command and response frame length
`define SD_CMD_BITS           48
// Start bit, transmission bit, index and argument
`define SD_CMD_PAYLOAD_BITS   40
`define SD_CRC7_BITS          7

// Idle cycles before the response start bit is looked for
`define SD_TURNAROUND         3

// ====================
// Data lines
// ====================

`define SD_DAT_LANES          4
// 512-bit block over four lanes
`define SD_BLOCK_NIBBLES      128
`define SD_CRC16_BITS         16
// CMD6 status block, nibble holding the access mode
`define SD_ACCESS_MODE_NIBBLE 33

`endif

//--- sd_host_pkg.sv
`include "sd_host_cfg.svh"

package sd_host_pkg;

    // ====================
    // FSM states
    // ====================

    typedef enum logic [2:0] {
        cmd_idle,
        cmd_load,
        cmd_shift,
        cmd_crc,
        cmd_stop
    } cmd_state_e;

    typedef enum logic [1:0] {
        resp_idle,
        resp_wait_start,
        resp_shift,
        resp_check
    } resp_state_e;

    typedef enum logic [2:0] {
        dat_idle,
        dat_wait_start,
        dat_data,
        dat_crc,
        dat_end_check
    } dat_state_e;

    // Response kind expected after a command
    typedef enum logic {
        resp_none,
        resp_r48
    } resp_type_e;

    // ====================
    // Request and result records
    // ====================

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] argument;
        resp_type_e  resp_type;
        logic        dat_in;
    } sd_cmd_req_t;

    typedef struct packed {
        logic [`SD_CMD_BITS-1:0] data;
        logic                    crc_err;
    } sd_resp_t;

    typedef struct packed {
        logic                     crc_err;
        logic [`SD_DAT_LANES-1:0] access_mode;
    } sd_dat_status_t;

endpackage

//--- sd_crc7.sv
`timescale 1ns/10ps
`include "sd_host_cfg.svh"

module sd_crc7 (
    input  logic                     clk_int,
    input  logic                     rst,
    input  logic                     clear,
    input  logic                     en,
    input  logic                     din,
    output logic [`SD_CRC7_BITS-1:0] crc
);

    // x^7 + x^3 + 1, the x^7 term is the feedback itself
    localparam logic [`SD_CRC7_BITS-1:0] POLY = 7'h09;

    logic fb;

    assign fb = din ^ crc[`SD_CRC7_BITS-1];

    // One bit per enabled cycle, MSB of the frame first
    always_ff @(posedge clk_int) begin
        if (rst) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            crc <= {crc[`SD_CRC7_BITS-2:0], 1'b0} ^ ({`SD_CRC7_BITS{fb}} & POLY);
        end
    end

endmodule

//--- sd_crc16.sv
`timescale 1ns/10ps
`include "sd_host_cfg.svh"

module sd_crc16 (
    input  logic                      clk_int,
    input  logic                      rst,
    input  logic                      clear,
    input  logic                      en,
    input  logic                      din,
    output logic [`SD_CRC16_BITS-1:0] crc
);

    // CCITT form, x^16 + x^12 + x^5 + 1
    localparam logic [`SD_CRC16_BITS-1:0] POLY = 16'h1021;

    logic fb;

    assign fb = din ^ crc[`SD_CRC16_BITS-1];

    // Serial update for a single DAT lane
    always_ff @(posedge clk_int) begin
        if (rst) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            crc <= {crc[`SD_CRC16_BITS-2:0], 1'b0} ^ ({`SD_CRC16_BITS{fb}} & POLY);
        end
    end

endmodule

//--- sd_cmd_path.sv
`timescale 1ns/10ps
`include "sd_host_cfg.svh"

module sd_cmd_path (
    input  logic                     clk_int,
    input  logic                     rst,
    input  logic                     cmd_start,
    input  sd_host_pkg::sd_cmd_req_t cmd_req,
    output logic                     busy,
    output logic                     cmd_done,
    output logic                     dat_arm,
    output logic                     resp_valid,
    output sd_host_pkg::sd_resp_t    resp,
    output logic                     sd_cmd_out,
    output logic                     sd_cmd_oe,
    input  logic                     sd_cmd_in
);

    localparam int CNT_W     = $clog2(`SD_CMD_BITS);
    localparam int TA_W      = $clog2(`SD_TURNAROUND + 1);
    localparam int CRC_IDX_W = $clog2(`SD_CRC7_BITS);
    localparam int TAIL_BITS = `SD_CMD_BITS - `SD_CMD_PAYLOAD_BITS;

    localparam logic [CNT_W-1:0] TX_LAST     = CNT_W'(`SD_CMD_PAYLOAD_BITS - 1);
    localparam logic [CNT_W-1:0] CRC_LAST    = CNT_W'(`SD_CRC7_BITS - 1);
    localparam logic [CNT_W-1:0] RX_LAST     = CNT_W'(`SD_CMD_BITS - 2);
    localparam logic [CNT_W-1:0] RX_CRC_STOP = CNT_W'(TAIL_BITS);
    localparam logic [TA_W-1:0]  TA_LOAD     = TA_W'(`SD_TURNAROUND);

    sd_host_pkg::cmd_state_e  cmd_state;
    sd_host_pkg::resp_state_e resp_state;
    sd_host_pkg::sd_cmd_req_t req_q;

    logic [`SD_CMD_BITS-1:0]  frame_sr;
    logic [CNT_W-1:0]         tx_cnt;
    logic [CNT_W-1:0]         rx_cnt;
    logic [TA_W-1:0]          ta_cnt;
    logic [`SD_CRC7_BITS-1:0] tx_crc;
    logic [`SD_CRC7_BITS-1:0] rx_crc;
    logic                     rx_start;
    logic                     rx_shift;
    logic                     rx_crc_en;

    assign busy = (cmd_state != sd_host_pkg::cmd_idle);

    // ====================
    // Command transmit
    // ====================

    always_ff @(posedge clk_int) begin
        if (cmd_state == sd_host_pkg::cmd_idle && cmd_start) begin
            req_q <= cmd_req;
        end
    end

    always_ff @(posedge clk_int) begin
        if (rst) begin
            cmd_state <= sd_host_pkg::cmd_idle;
            tx_cnt    <= '0;
            cmd_done  <= 1'b0;
            dat_arm   <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            dat_arm  <= 1'b0;
            case (cmd_state)
                sd_host_pkg::cmd_idle: begin
                    if (cmd_start) begin
                        cmd_state <= sd_host_pkg::cmd_load;
                    end
                end
                sd_host_pkg::cmd_load: begin
                    tx_cnt    <= TX_LAST;
                    cmd_state <= sd_host_pkg::cmd_shift;
                end
                sd_host_pkg::cmd_shift: begin
                    tx_cnt <= tx_cnt - 1'b1;
                    if (tx_cnt == '0) begin
                        tx_cnt    <= CRC_LAST;
                        cmd_state <= sd_host_pkg::cmd_crc;
                    end
                end
                sd_host_pkg::cmd_crc: begin
                    tx_cnt <= tx_cnt - 1'b1;
                    if (tx_cnt == '0) begin
                        cmd_state <= sd_host_pkg::cmd_stop;
                    end
                end
                sd_host_pkg::cmd_stop: begin
                    cmd_done  <= 1'b1;
                    dat_arm   <= req_q.dat_in;
                    cmd_state <= sd_host_pkg::cmd_idle;
                end
                default: cmd_state <= sd_host_pkg::cmd_idle;
            endcase
        end
    end

    // Payload bits first, then CRC7 MSB first, then the end bit
    always_comb begin
        case (cmd_state)
            sd_host_pkg::cmd_shift: sd_cmd_out = frame_sr[`SD_CMD_BITS-1];
            sd_host_pkg::cmd_crc:   sd_cmd_out = tx_crc[tx_cnt[CRC_IDX_W-1:0]];
            default:                sd_cmd_out = 1'b1;
        endcase
    end

    assign sd_cmd_oe = (cmd_state == sd_host_pkg::cmd_shift) ||
                       (cmd_state == sd_host_pkg::cmd_crc) ||
                       (cmd_state == sd_host_pkg::cmd_stop);

    sd_crc7 u_tx_crc (
        .clk_int (clk_int),
        .rst     (rst),
        .clear   (cmd_state == sd_host_pkg::cmd_load),
        .en      (cmd_state == sd_host_pkg::cmd_shift),
        .din     (frame_sr[`SD_CMD_BITS-1]),
        .crc     (tx_crc)
    );

    // ====================
    // Response receive
    // ====================

    assign rx_start  = (resp_state == sd_host_pkg::resp_wait_start) && (ta_cnt == '0) &&
                       !sd_cmd_in;
    assign rx_shift  = rx_start || (resp_state == sd_host_pkg::resp_shift);
    // Start bit through argument, bit positions 47 down to 8
    assign rx_crc_en = rx_start ||
                       ((resp_state == sd_host_pkg::resp_shift) && (rx_cnt >= RX_CRC_STOP));

    always_ff @(posedge clk_int) begin
        if (rst) begin
            resp_state <= sd_host_pkg::resp_idle;
            rx_cnt     <= '0;
            ta_cnt     <= '0;
        end else begin
            case (resp_state)
                sd_host_pkg::resp_idle: begin
                end
                sd_host_pkg::resp_wait_start: begin
                    if (ta_cnt != '0) begin
                        ta_cnt <= ta_cnt - 1'b1;
                    end else if (rx_start) begin
                        rx_cnt     <= RX_LAST;
                        resp_state <= sd_host_pkg::resp_shift;
                    end
                end
                sd_host_pkg::resp_shift: begin
                    rx_cnt <= rx_cnt - 1'b1;
                    if (rx_cnt == '0) begin
                        resp_state <= sd_host_pkg::resp_check;
                    end
                end
                sd_host_pkg::resp_check: resp_state <= sd_host_pkg::resp_idle;
            endcase
            // A new command takes the shift register back
            if (cmd_state == sd_host_pkg::cmd_load) begin
                resp_state <= sd_host_pkg::resp_idle;
            end else if (cmd_state == sd_host_pkg::cmd_stop &&
                         req_q.resp_type == sd_host_pkg::resp_r48) begin
                ta_cnt     <= TA_LOAD;
                resp_state <= sd_host_pkg::resp_wait_start;
            end
        end
    end

    sd_crc7 u_rx_crc (
        .clk_int (clk_int),
        .rst     (rst),
        .clear   (resp_state == sd_host_pkg::resp_idle),
        .en      (rx_crc_en),
        .din     (sd_cmd_in),
        .crc     (rx_crc)
    );

    // Shared by the outgoing frame and the incoming response
    always_ff @(posedge clk_int) begin
        if (cmd_state == sd_host_pkg::cmd_load) begin
            frame_sr <= {1'b0, 1'b1, req_q.index, req_q.argument, {TAIL_BITS{1'b1}}};
        end else if (cmd_state == sd_host_pkg::cmd_shift) begin
            frame_sr <= {frame_sr[`SD_CMD_BITS-2:0], 1'b1};
        end else if (rx_shift) begin
            frame_sr <= {frame_sr[`SD_CMD_BITS-2:0], sd_cmd_in};
        end
    end

    assign resp_valid = (resp_state == sd_host_pkg::resp_check);

    always_comb begin
        resp.data    = frame_sr;
        resp.crc_err = (rx_crc != frame_sr[`SD_CRC7_BITS:1]) || !frame_sr[0];
    end

    a_start_not_busy: assert property (@(posedge clk_int) disable iff (rst)
        busy |-> !cmd_start);

    a_no_rx_while_driving: assert property (@(posedge clk_int) disable iff (rst)
        !(sd_cmd_oe && resp_state == sd_host_pkg::resp_shift));

endmodule

//--- sd_dat_rx.sv
`timescale 1ns/10ps
`include "sd_host_cfg.svh"

module sd_dat_rx (
    input  logic                        clk_int,
    input  logic                        rst,
    input  logic                        dat_arm,
    input  logic [`SD_DAT_LANES-1:0]    sd_dat_in,
    output logic                        dat_valid,
    output sd_host_pkg::sd_dat_status_t dat_status,
    output logic                        dat0_idle
);

    localparam int NIB_W = $clog2(`SD_BLOCK_NIBBLES);
    localparam int CRC_W = $clog2(`SD_CRC16_BITS);

    localparam logic [NIB_W-1:0] NIB_LAST   = NIB_W'(`SD_BLOCK_NIBBLES - 1);
    // Counter runs down, so nibble 33 sits at count 94
    localparam logic [NIB_W-1:0] ACCESS_CNT =
        NIB_W'(`SD_BLOCK_NIBBLES - 1 - `SD_ACCESS_MODE_NIBBLE);
    localparam logic [CRC_W-1:0] CRC_LAST   = CRC_W'(`SD_CRC16_BITS - 1);

    sd_host_pkg::dat_state_e dat_state;

    logic [`SD_DAT_LANES-1:0]  dat_q;
    logic [NIB_W-1:0]          nib_cnt;
    logic [CRC_W-1:0]          crc_cnt;
    logic                      crc_err_q;
    logic [`SD_DAT_LANES-1:0]  access_q;
    logic [`SD_DAT_LANES-1:0]  lane_bit;
    logic [`SD_CRC16_BITS-1:0] lane_crc [`SD_DAT_LANES];

    // Input register, lines idle high
    always_ff @(posedge clk_int) begin
        if (rst) begin
            dat_q <= '1;
        end else begin
            dat_q <= sd_dat_in;
        end
    end

    assign dat0_idle = dat_q[0];

    // ====================
    // Per-lane CRC16
    // ====================

    for (genvar i = 0; i < `SD_DAT_LANES; i++) begin : g_lane
        sd_crc16 u_crc (
            .clk_int (clk_int),
            .rst     (rst),
            .clear   (dat_state == sd_host_pkg::dat_wait_start),
            .en      (dat_state == sd_host_pkg::dat_data),
            .din     (dat_q[i]),
            .crc     (lane_crc[i])
        );
        // Expected CRC bit for the nibble now in dat_q
        assign lane_bit[i] = lane_crc[i][crc_cnt];
    end

    // ====================
    // Block FSM
    // ====================

    always_ff @(posedge clk_int) begin
        if (rst) begin
            dat_state <= sd_host_pkg::dat_idle;
            nib_cnt   <= '0;
            crc_cnt   <= '0;
            crc_err_q <= 1'b0;
        end else begin
            case (dat_state)
                sd_host_pkg::dat_idle: begin
                    if (dat_arm) begin
                        dat_state <= sd_host_pkg::dat_wait_start;
                    end
                end
                sd_host_pkg::dat_wait_start: begin
                    crc_err_q <= 1'b0;
                    nib_cnt   <= NIB_LAST;
                    // All four lanes must start together
                    if (dat_q == '0) begin
                        dat_state <= sd_host_pkg::dat_data;
                    end
                end
                sd_host_pkg::dat_data: begin
                    nib_cnt <= nib_cnt - 1'b1;
                    if (nib_cnt == '0) begin
                        crc_cnt   <= CRC_LAST;
                        dat_state <= sd_host_pkg::dat_crc;
                    end
                end
                sd_host_pkg::dat_crc: begin
                    if (lane_bit != dat_q) begin
                        crc_err_q <= 1'b1;
                    end
                    crc_cnt <= crc_cnt - 1'b1;
                    if (crc_cnt == '0) begin
                        dat_state <= sd_host_pkg::dat_end_check;
                    end
                end
                sd_host_pkg::dat_end_check: dat_state <= sd_host_pkg::dat_idle;
                default: dat_state <= sd_host_pkg::dat_idle;
            endcase
        end
    end

    always_ff @(posedge clk_int) begin
        if (dat_state == sd_host_pkg::dat_data && nib_cnt == ACCESS_CNT) begin
            access_q <= dat_q;
        end
    end

    // End nibble is in dat_q during end_check
    assign dat_valid = (dat_state == sd_host_pkg::dat_end_check);

    always_comb begin
        dat_status.crc_err     = crc_err_q || (dat_q != '1);
        dat_status.access_mode = access_q;
    end

    a_valid_after_crc: assert property (@(posedge clk_int) disable iff (rst)
        dat_valid |-> ($past(dat_state) == sd_host_pkg::dat_crc) && ($past(crc_cnt) == '0));

endmodule

//--- sd_host.sv
`timescale 1ns/10ps
`include "sd_host_cfg.svh"

module sd_host (
    input  logic                        clk_int,
    input  logic                        rst,
    input  logic                        cmd_start,
    input  sd_host_pkg::sd_cmd_req_t    cmd_req,
    output logic                        busy,
    output logic                        cmd_done,
    output logic                        resp_valid,
    output sd_host_pkg::sd_resp_t       resp,
    output logic                        dat_valid,
    output sd_host_pkg::sd_dat_status_t dat_status,
    output logic                        dat0_idle,
    output logic                        sd_cmd_out,
    output logic                        sd_cmd_oe,
    input  logic                        sd_cmd_in,
    input  logic [`SD_DAT_LANES-1:0]    sd_dat_in
);

    // Command end to block receiver
    logic dat_arm;

    sd_cmd_path u_cmd_path (
        .clk_int    (clk_int),
        .rst        (rst),
        .cmd_start  (cmd_start),
        .cmd_req    (cmd_req),
        .busy       (busy),
        .cmd_done   (cmd_done),
        .dat_arm    (dat_arm),
        .resp_valid (resp_valid),
        .resp       (resp),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sd_cmd_in  (sd_cmd_in)
    );

    sd_dat_rx u_dat_rx (
        .clk_int    (clk_int),
        .rst        (rst),
        .dat_arm    (dat_arm),
        .sd_dat_in  (sd_dat_in),
        .dat_valid  (dat_valid),
        .dat_status (dat_status),
        .dat0_idle  (dat0_idle)
    );

endmodule

//--- sd_card_model.sv
`timescale 1ns/10ps
`include "sd_host_cfg.svh"

module sd_card_model (
    input  logic                     clk_int,
    input  logic                     sd_cmd_out,
    input  logic                     sd_cmd_oe,
    output logic                     sd_cmd_in,
    output logic [`SD_DAT_LANES-1:0] sd_dat_in,
    input  logic                     send_resp,
    input  logic                     send_dat,
    input  logic                     bad_resp_crc,
    input  logic                     bad_dat_crc,
    input  logic [3:0]               access_nibble,
    output logic [5:0]               rx_index,
    output logic [31:0]              rx_arg,
    output logic                     rx_ok,
    output logic [47:0]              resp_frame
);

    integer card_seed = 32'hb372_2487;

    // CRC7, polynomial x^7 + x^3 + 1, message MSB first
    function automatic logic [6:0] crc7_calc(input logic [39:0] msg);
        logic [6:0] c;
        logic       top;
        c = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            top = msg[i] ^ c[6];
            c = {c[5:0], 1'b0};
            if (top) c = c ^ 7'b000_1001;
        end
        return c;
    endfunction

    // CRC16 CCITT over one lane of a block
    function automatic logic [15:0] crc16_calc(input logic [127:0] msg);
        logic [15:0] c;
        logic        top;
        c = 16'd0;
        for (int i = 127; i >= 0; i--) begin
            top = msg[i] ^ c[15];
            c = {c[14:0], 1'b0};
            if (top) c = c ^ 16'b0001_0000_0010_0001;
        end
        return c;
    endfunction

    // Echo index and argument after a few idle cycles
    task automatic send_response();
        logic [6:0] crc;
        int         gap;
        crc = crc7_calc({2'b00, rx_index, rx_arg});
        if (bad_resp_crc) crc[0] = ~crc[0];
        resp_frame = {2'b00, rx_index, rx_arg, crc, 1'b1};
        gap = 3 + ($unsigned($random(card_seed)) % 3);
        repeat (gap) @(posedge clk_int);
        for (int i = 47; i >= 0; i--) begin
            #1 sd_cmd_in = resp_frame[i];
            @(posedge clk_int);
        end
        #1 sd_cmd_in = 1'b1;
    endtask

    task automatic send_block();
        logic [3:0]   blk [128];
        logic [127:0] lane_bits;
        logic [15:0]  lane_crc [4];
        for (int n = 0; n < 128; n++) blk[n] = 4'($random(card_seed));
        blk[`SD_ACCESS_MODE_NIBBLE] = access_nibble;
        for (int l = 0; l < 4; l++) begin
            for (int n = 0; n < 128; n++) lane_bits[127-n] = blk[n][l];
            lane_crc[l] = crc16_calc(lane_bits);
        end
        if (bad_dat_crc) lane_crc[1][5] = ~lane_crc[1][5];
        repeat (2) @(posedge clk_int);
        #1 sd_dat_in = 4'h0;
        @(posedge clk_int);
        for (int n = 0; n < 128; n++) begin
            #1 sd_dat_in = blk[n];
            @(posedge clk_int);
        end
        for (int k = 15; k >= 0; k--) begin
            #1 sd_dat_in = {lane_crc[3][k], lane_crc[2][k], lane_crc[1][k], lane_crc[0][k]};
            @(posedge clk_int);
        end
        // End nibble, then the pull-ups hold the lines high
        #1 sd_dat_in = 4'hf;
    endtask

    initial begin
        logic [47:0] cmd_sr;
        int          cmd_cnt;
        sd_cmd_in  = 1'b1;
        sd_dat_in  = 4'hf;
        rx_index   = '0;
        rx_arg     = '0;
        rx_ok      = 1'b0;
        resp_frame = '0;
        cmd_sr     = '0;
        cmd_cnt    = 0;
        forever begin
            @(posedge clk_int);
            if (sd_cmd_oe) begin
                cmd_sr = {cmd_sr[46:0], sd_cmd_out};
                cmd_cnt++;
                if (cmd_cnt == 48) begin
                    cmd_cnt  = 0;
                    rx_index = cmd_sr[45:40];
                    rx_arg   = cmd_sr[39:8];
                    rx_ok    = !cmd_sr[47] && cmd_sr[46] && cmd_sr[0] &&
                               (crc7_calc(cmd_sr[47:8]) == cmd_sr[7:1]);
                    if (send_resp) send_response();
                    if (send_dat) send_block();
                end
            end
        end
    end

endmodule

//--- tb_sd_host.sv
`timescale 1ns/10ps
`include "sd_host_cfg.svh"

module tb_sd_host;

    logic                        clk_int;
    logic                        rst;
    logic                        cmd_start;
    sd_host_pkg::sd_cmd_req_t    cmd_req;
    logic                        busy;
    logic                        cmd_done;
    logic                        resp_valid;
    sd_host_pkg::sd_resp_t       resp;
    logic                        dat_valid;
    sd_host_pkg::sd_dat_status_t dat_status;
    logic                        dat0_idle;
    logic                        sd_cmd_out;
    logic                        sd_cmd_oe;
    logic                        sd_cmd_in;
    logic [`SD_DAT_LANES-1:0]    sd_dat_in;

    logic        send_resp;
    logic        send_dat;
    logic        bad_resp_crc;
    logic        bad_dat_crc;
    logic [3:0]  access_nibble;
    logic [5:0]  card_index;
    logic [31:0] card_arg;
    logic        card_ok;
    logic [47:0] card_frame;
    logic        quiet;
    logic        idle_expected;
    int          oe_len;
    integer      seed;

    sd_host u_dut (.*);

    sd_card_model u_card (
        .clk_int       (clk_int),
        .sd_cmd_out    (sd_cmd_out),
        .sd_cmd_oe     (sd_cmd_oe),
        .sd_cmd_in     (sd_cmd_in),
        .sd_dat_in     (sd_dat_in),
        .send_resp     (send_resp),
        .send_dat      (send_dat),
        .bad_resp_crc  (bad_resp_crc),
        .bad_dat_crc   (bad_dat_crc),
        .access_nibble (access_nibble),
        .rx_index      (card_index),
        .rx_arg        (card_arg),
        .rx_ok         (card_ok),
        .resp_frame    (card_frame)
    );

    initial begin
        clk_int = 1'b0;
        forever #50 clk_int = ~clk_int;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // Length of the current oe-high run
    always @(posedge clk_int) begin
        if (rst || !sd_cmd_oe) oe_len <= 0;
        else oe_len <= oe_len + 1;
    end

    // ====================
    // Checks
    // ====================

    a_reset_idle: assert property (@(posedge clk_int) rst |=>
        (!cmd_done && !resp_valid && !dat_valid && !sd_cmd_oe && sd_cmd_out && !busy))
        else fail_run($sformatf("ERR reset outputs oe=%h out=%h done=%h rv=%h dv=%h busy=%h",
            $sampled(sd_cmd_oe), $sampled(sd_cmd_out), $sampled(cmd_done),
            $sampled(resp_valid), $sampled(dat_valid), $sampled(busy)));
    a_busy: assert property (@(posedge clk_int) disable iff (rst)
        (sd_cmd_oe || cmd_done) |-> busy == sd_cmd_oe)
        else fail_run($sformatf("ERR busy exp %h got %h",
            $sampled(sd_cmd_oe), $sampled(busy)));
    a_oe_len: assert property (@(posedge clk_int) disable iff (rst)
        $fell(sd_cmd_oe) |-> oe_len == 48)
        else fail_run($sformatf("ERR sd_cmd_oe length exp %h got %h", 48, $sampled(oe_len)));
    a_done_pulse: assert property (@(posedge clk_int) disable iff (rst)
        cmd_done == $fell(sd_cmd_oe))
        else fail_run("cmd_done did not follow the end of the command frame");
    a_card_ok: assert property (@(posedge clk_int) disable iff (rst) cmd_done |-> card_ok)
        else fail_run("Card saw a bad command CRC7 or end bit");
    a_card_fields: assert property (@(posedge clk_int) disable iff (rst)
        cmd_done |-> (card_index == cmd_req.index) && (card_arg == cmd_req.argument))
        else fail_run($sformatf("ERR index/argument exp %h/%h got %h/%h",
            $sampled(cmd_req.index), $sampled(cmd_req.argument),
            $sampled(card_index), $sampled(card_arg)));
    a_resp_data: assert property (@(posedge clk_int) disable iff (rst)
        resp_valid |-> resp.data == card_frame)
        else fail_run($sformatf("ERR resp.data exp %h got %h",
            $sampled(card_frame), $sampled(resp.data)));
    a_resp_crc: assert property (@(posedge clk_int) disable iff (rst)
        resp_valid |-> resp.crc_err == bad_resp_crc)
        else fail_run($sformatf("ERR resp.crc_err exp %h got %h",
            $sampled(bad_resp_crc), $sampled(resp.crc_err)));
    a_dat_crc: assert property (@(posedge clk_int) disable iff (rst)
        dat_valid |-> dat_status.crc_err == bad_dat_crc)
        else fail_run($sformatf("ERR dat_status.crc_err exp %h got %h",
            $sampled(bad_dat_crc), $sampled(dat_status.crc_err)));
    a_dat_mode: assert property (@(posedge clk_int) disable iff (rst)
        dat_valid |-> dat_status.access_mode == access_nibble)
        else fail_run($sformatf("ERR dat_status.access_mode exp %h got %h",
            $sampled(access_nibble), $sampled(dat_status.access_mode)));
    a_quiet: assert property (@(posedge clk_int) disable iff (rst)
        quiet |-> !resp_valid && !dat_valid)
        else fail_run("Result pulse seen after a command without response or data");
    a_dat0_idle: assert property (@(posedge clk_int) disable iff (rst)
        idle_expected |-> dat0_idle)
        else fail_run($sformatf("ERR dat0_idle exp %h got %h", 1'b1, $sampled(dat0_idle)));

    // ====================
    // Stimulus
    // ====================

    task automatic set_card(input logic sr, input logic sd, input logic br, input logic bd,
                            input logic [3:0] nib);
        @(posedge clk_int);
        #1;
        send_resp     = sr;
        send_dat      = sd;
        bad_resp_crc  = br;
        bad_dat_crc   = bd;
        access_nibble = nib;
    endtask

    task automatic issue_cmd(input logic [5:0] idx, input logic [31:0] arg,
                             input sd_host_pkg::resp_type_e rtype, input logic dat);
        int waited;
        @(posedge clk_int);
        #1;
        cmd_req.index     = idx;
        cmd_req.argument  = arg;
        cmd_req.resp_type = rtype;
        cmd_req.dat_in    = dat;
        cmd_start         = 1'b1;
        @(posedge clk_int);
        #1 cmd_start = 1'b0;
        waited = 0;
        while (!cmd_done) begin
            @(negedge clk_int);
            waited++;
            if (waited > 100) fail_run("Timeout waiting for cmd_done");
        end
    endtask

    task automatic wait_resp();
        int waited;
        waited = 0;
        while (!resp_valid) begin
            @(negedge clk_int);
            waited++;
            if (waited > 200) fail_run("Timeout waiting for resp_valid");
        end
    endtask

    task automatic wait_dat();
        int waited;
        waited = 0;
        while (!dat_valid) begin
            @(negedge clk_int);
            waited++;
            if (waited > 400) fail_run("Timeout waiting for dat_valid");
        end
    endtask

    initial begin
        logic [31:0] rnd;
        seed          = 32'hb372_2487;
        rst           = 1'b1;
        cmd_start     = 1'b0;
        cmd_req       = '0;
        send_resp     = 1'b0;
        send_dat      = 1'b0;
        bad_resp_crc  = 1'b0;
        bad_dat_crc   = 1'b0;
        access_nibble = 4'h0;
        quiet         = 1'b0;
        idle_expected = 1'b0;
        repeat (2) @(posedge clk_int);
        #1 rst = 1'b0;

        // R48 commands, one with a corrupted response CRC
        for (int i = 0; i < 4; i++) begin
            set_card(1'b1, 1'b0, i == 2, 1'b0, 4'h0);
            rnd = $random(seed);
            issue_cmd(rnd[5:0], $random(seed), sd_host_pkg::resp_r48, 1'b0);
            wait_resp();
        end

        // Block reads, the second with a bad lane CRC
        for (int i = 0; i < 2; i++) begin
            rnd = $random(seed);
            set_card(1'b0, 1'b1, 1'b0, i == 1, rnd[3:0]);
            issue_cmd(6'd6, $random(seed), sd_host_pkg::resp_none, 1'b1);
            wait_dat();
            @(posedge clk_int);
            #1 idle_expected = 1'b1;
            @(posedge clk_int);
            #1 idle_expected = 1'b0;
        end

        // No response and no data expected
        // Card still answers on both lines
        set_card(1'b1, 1'b1, 1'b0, 1'b0, 4'h0);
        rnd = $random(seed);
        issue_cmd(rnd[5:0], $random(seed), sd_host_pkg::resp_none, 1'b0);
        @(posedge clk_int);
        #1 quiet = 1'b1;
        repeat (300) @(posedge clk_int);
        #1 quiet = 1'b0;

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
sd_host_pkg.sv
sd_crc7.sv
sd_crc16.sv
sd_cmd_path.sv
sd_dat_rx.sv
sd_host.sv
sd_card_model.sv
tb_sd_host.sv

//--- Makefile
TOP = tb_sd_host

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
